// File: hw/sound_pkg.sv
`default_nettype none

package sound_pkg;

   localparam int NUM_OSC    = 4;
   localparam int DOC_PERIOD = 16;                // Clock cycles per synthesizer slot
   localparam int PHASE_W    = $clog2(DOC_PERIOD);
   localparam int OSC_W      = $clog2(NUM_OSC);   // Oscillator index width
   localparam int ADDR_W     = 16;                // 64 KB sound address space
   localparam int ACC_W      = 24;                // Phase accumulator width
   localparam int SUM_W      = 8 + OSC_W;         // Mixer sum without overflow

   // Host register offsets
   typedef enum logic [1:0] {
      SNDCTL  = 2'd0,
      SNDDATA = 2'd1,
      SNDAPL  = 2'd2,
      SNDAPH  = 2'd3
   } glu_reg_e;

   typedef enum logic [1:0] {
      ST_IDLE      = 2'd0,
      ST_PENDING   = 2'd1,   // Waiting for the next synthesizer slot
      ST_FINISHING = 2'd2
   } glu_state_e;

   // Synthesizer register bank from the top 3 bits of the register address
   typedef enum logic [2:0] {
      REG_FREQ_LO = 3'd0,   // 0x00 + osc
      REG_FREQ_HI = 3'd1,   // 0x20 + osc
      REG_VOLUME  = 3'd2,   // 0x40 + osc
      REG_CONTROL = 3'd5    // 0xA0 + osc
   } doc_reg_e;

endpackage

`default_nettype wire

// File: hw/sound_glu.sv
`timescale 1ns/1ns
`default_nettype none

module sound_glu import sound_pkg::*; (
   input  wire               clk,
   input  wire               reset,
   input  wire               select,
   input  wire               wr,
   input  wire  [1:0]        host_addr,
   input  wire  [7:0]        host_data_in,
   input  wire  [7:0]        ram_rdata,
   input  wire  [7:0]        doc_rdata,
   output logic [7:0]        host_data_out,
   output logic [ADDR_W-1:0] sound_addr,
   output logic [7:0]        sound_data_out,
   output logic              ram_wr,
   output logic              doc_wr,
   output logic              doc_enable,
   output logic [3:0]        master_volume
);

   glu_reg_e           host_reg;
   glu_state_e         state;
   logic [PHASE_W-1:0] phase;
   logic               select_d;
   logic               host_edge;
   logic               write_pending;
   logic               ram_access;
   logic               auto_increment;
   logic               busy;
   logic [7:0]         read_buf;
   logic [7:0]         sound_rdata;

   assign host_reg    = glu_reg_e'(host_addr);
   assign host_edge   = select && !select_d;   // Rising edge of select
   assign busy        = (state == ST_PENDING);
   assign sound_rdata = ram_access ? ram_rdata : doc_rdata;

   // Synthesizer slot timer
   always_ff @(posedge clk) begin
      if (reset) begin
         phase      <= '0;
         doc_enable <= 1'b0;
      end else begin
         phase      <= (phase == PHASE_W'(DOC_PERIOD - 1)) ? '0 : phase + 1'b1;
         doc_enable <= (phase == '0);
      end
   end

   // Access scheduling and host register writes
   always_ff @(posedge clk) begin
      if (reset) begin
         state          <= ST_IDLE;
         write_pending  <= 1'b0;
         ram_wr         <= 1'b0;
         doc_wr         <= 1'b0;
         select_d       <= 1'b0;
         ram_access     <= 1'b0;
         auto_increment <= 1'b0;
         master_volume  <= 4'd0;
         sound_addr     <= '0;
      end else begin
         select_d <= select;
         ram_wr   <= 1'b0;
         doc_wr   <= 1'b0;

         // doc_enable means the synthesizer just ran its cycle,
         // so the bus is free for the held host access
         case (state)
            ST_PENDING: begin
               if (doc_enable) begin
                  state  <= ST_FINISHING;
                  ram_wr <= ram_access && write_pending;
                  doc_wr <= !ram_access && write_pending;
               end
            end
            ST_FINISHING: begin
               state         <= ST_IDLE;
               write_pending <= 1'b0;
               if (auto_increment) begin
                  sound_addr <= sound_addr + 1'b1;
               end
            end
            default: state <= ST_IDLE;
         endcase

         // A new data access replaces any pending one
         if (host_edge) begin
            case (host_reg)
               SNDCTL: begin
                  if (wr) begin
                     ram_access     <= host_data_in[6];
                     auto_increment <= host_data_in[5];
                     master_volume  <= host_data_in[3:0];
                  end
               end
               SNDDATA: begin
                  state         <= ST_PENDING;
                  write_pending <= wr;
               end
               SNDAPL: begin
                  if (wr) begin
                     sound_addr[7:0] <= host_data_in;
                  end
               end
               SNDAPH: begin
                  if (wr) begin
                     sound_addr[ADDR_W-1:8] <= host_data_in;
                  end
               end
            endcase
         end
      end
   end

   // Data path registers
   always_ff @(posedge clk) begin
      if (state == ST_FINISHING && !write_pending) begin
         read_buf <= sound_rdata;   // Fetched byte for the next SNDDATA read
      end
      if (host_edge) begin
         if (wr) begin
            if (host_reg == SNDDATA) begin
               sound_data_out <= host_data_in;
            end
         end else begin
            case (host_reg)
               SNDCTL:  host_data_out <= {busy, ram_access, auto_increment, 1'b1,
                                          master_volume};
               SNDDATA: host_data_out <= read_buf;   // Result of previous fetch
               SNDAPL:  host_data_out <= sound_addr[7:0];
               SNDAPH:  host_data_out <= sound_addr[ADDR_W-1:8];
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// File: hw/sound_ram.sv
`timescale 1ns/1ns
`default_nettype none

module sound_ram import sound_pkg::*; (
   input  wire               clk,
   input  wire               ram_wr,
   input  wire  [ADDR_W-1:0] sound_addr,
   input  wire  [7:0]        sound_data_out,
   output logic [7:0]        ram_rdata
);

   logic [7:0] mem [0:(2**ADDR_W)-1];   // Sample storage

   // Registered read returns the old byte on a write
   always_ff @(posedge clk) begin
      if (ram_wr) begin
         mem[sound_addr] <= sound_data_out;
      end
      ram_rdata <= mem[sound_addr];
   end

endmodule

`default_nettype wire

// File: hw/doc_regs.sv
`timescale 1ns/1ns
`default_nettype none

module doc_regs import sound_pkg::*; (
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      doc_wr,
   input  wire  [7:0]               reg_addr,
   input  wire  [7:0]               wdata,
   output logic [7:0]               doc_rdata,
   output logic [NUM_OSC-1:0][15:0] freq,
   output logic [NUM_OSC-1:0][7:0]  volume,
   output logic [NUM_OSC-1:0]       halt
);

   doc_reg_e         bank;
   logic [OSC_W-1:0] osc;
   logic             osc_valid;

   assign bank      = doc_reg_e'(reg_addr[7:5]);
   assign osc       = reg_addr[OSC_W-1:0];
   assign osc_valid = (reg_addr[4:OSC_W] == '0);   // Oscillator number in range

   always_ff @(posedge clk) begin
      if (reset) begin
         freq   <= '0;
         volume <= '0;
         halt   <= '1;   // All voices start halted
      end else if (doc_wr && osc_valid) begin
         case (bank)
            REG_FREQ_LO: freq[osc][7:0]  <= wdata;
            REG_FREQ_HI: freq[osc][15:8] <= wdata;
            REG_VOLUME:  volume[osc]     <= wdata;
            REG_CONTROL: halt[osc]       <= wdata[0];
            default: ;
         endcase
      end
   end

   // Unmapped banks and oscillators read as zero
   always_comb begin
      doc_rdata = 8'd0;
      if (osc_valid) begin
         case (bank)
            REG_FREQ_LO: doc_rdata = freq[osc][7:0];
            REG_FREQ_HI: doc_rdata = freq[osc][15:8];
            REG_VOLUME:  doc_rdata = volume[osc];
            REG_CONTROL: doc_rdata = {7'd0, halt[osc]};
            default:     doc_rdata = 8'd0;
         endcase
      end
   end

endmodule

`default_nettype wire

// File: hw/doc_oscillator.sv
`timescale 1ns/1ns
`default_nettype none

module doc_oscillator import sound_pkg::*; (
   input  wire        clk,
   input  wire        reset,
   input  wire        doc_enable,
   input  wire [15:0] freq,
   input  wire [7:0]  volume,
   input  wire        halt,
   output logic [7:0] sample
);

   logic [ACC_W-1:0] acc;
   logic [15:0]      product;

   // Phase advances once per synthesizer slot
   always_ff @(posedge clk) begin
      if (reset) begin
         acc <= '0;
      end else if (doc_enable && !halt) begin
         acc <= acc + ACC_W'(freq);
      end
   end

   // Sawtooth from the accumulator top byte, scaled by voice volume
   assign product = 16'(acc[ACC_W-1:ACC_W-8]) * 16'(volume);
   assign sample  = halt ? 8'd0 : product[15:8];

endmodule

`default_nettype wire

// File: hw/doc_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module doc_mixer import sound_pkg::*; (
   input  wire                     clk,
   input  wire                     reset,
   input  wire                     doc_enable,
   input  wire [NUM_OSC-1:0][7:0]  sample,
   input  wire [3:0]               master_volume,
   output logic [11:0]             audio_out
);

   logic [SUM_W-1:0]   sum;
   logic [SUM_W+3:0]   scaled;

   always_comb begin
      sum = '0;
      for (int i = 0; i < NUM_OSC; i++) begin
         sum = sum + SUM_W'(sample[i]);
      end
   end

   assign scaled = (SUM_W+4)'(sum) * (SUM_W+4)'(master_volume);   // Full width product

   // New output sample once per slot
   always_ff @(posedge clk) begin
      if (reset) begin
         audio_out <= 12'd0;
      end else if (doc_enable) begin
         audio_out <= 12'(scaled[SUM_W+3:4]);   // Divide by 16
      end
   end

endmodule

`default_nettype wire

// File: hw/sound_top.sv
`timescale 1ns/1ns
`default_nettype none

module sound_top import sound_pkg::*; (
   input  wire         clk,
   input  wire         reset,
   input  wire         select,
   input  wire         wr,
   input  wire  [1:0]  host_addr,
   input  wire  [7:0]  host_data_in,
   output logic [7:0]  host_data_out,
   output logic [11:0] audio_out
);

   logic [ADDR_W-1:0]        sound_addr;
   logic [7:0]               sound_data_out;
   logic [7:0]               ram_rdata;
   logic [7:0]               doc_rdata;
   logic                     ram_wr;
   logic                     doc_wr;
   logic                     doc_enable;
   logic [3:0]               master_volume;
   logic [NUM_OSC-1:0][15:0] osc_freq;
   logic [NUM_OSC-1:0][7:0]  osc_volume;
   logic [NUM_OSC-1:0]       osc_halt;
   logic [NUM_OSC-1:0][7:0]  osc_sample;

   sound_glu u_sound_glu (
      .clk            (clk),
      .reset          (reset),
      .select         (select),
      .wr             (wr),
      .host_addr      (host_addr),
      .host_data_in   (host_data_in),
      .ram_rdata      (ram_rdata),
      .doc_rdata      (doc_rdata),
      .host_data_out  (host_data_out),
      .sound_addr     (sound_addr),
      .sound_data_out (sound_data_out),
      .ram_wr         (ram_wr),
      .doc_wr         (doc_wr),
      .doc_enable     (doc_enable),
      .master_volume  (master_volume)
   );

   sound_ram u_sound_ram (
      .clk            (clk),
      .ram_wr         (ram_wr),
      .sound_addr     (sound_addr),
      .sound_data_out (sound_data_out),
      .ram_rdata      (ram_rdata)
   );

   // Register file sees only the low address byte
   doc_regs u_doc_regs (
      .clk       (clk),
      .reset     (reset),
      .doc_wr    (doc_wr),
      .reg_addr  (sound_addr[7:0]),
      .wdata     (sound_data_out),
      .doc_rdata (doc_rdata),
      .freq      (osc_freq),
      .volume    (osc_volume),
      .halt      (osc_halt)
   );

   for (genvar i = 0; i < NUM_OSC; i++) begin : g_osc
      doc_oscillator u_doc_oscillator (
         .clk        (clk),
         .reset      (reset),
         .doc_enable (doc_enable),
         .freq       (osc_freq[i]),
         .volume     (osc_volume[i]),
         .halt       (osc_halt[i]),
         .sample     (osc_sample[i])
      );
   end

   doc_mixer u_doc_mixer (
      .clk           (clk),
      .reset         (reset),
      .doc_enable    (doc_enable),
      .sample        (osc_sample),
      .master_volume (master_volume),
      .audio_out     (audio_out)
   );

endmodule

`default_nettype wire

// File: dv/sound_assertions.sv
`timescale 1ns/1ns
`default_nettype none

module sound_assertions import sound_pkg::*; (
   input wire               clk,
   input wire               reset,
   input wire               ram_wr,
   input wire               doc_wr,
   input wire               doc_enable,
   input wire               busy,
   input wire [NUM_OSC-1:0] osc_halt,
   input wire [11:0]        audio_out
);

   int                 fail_count = 0;
   logic [PHASE_W-1:0] gap;        // Cycles since the last slot pulse
   logic [PHASE_W:0]   busy_run;   // Consecutive busy cycles

   // First slot pulse comes one cycle after reset is released
   always_ff @(posedge clk) begin
      if (reset) begin
         gap      <= PHASE_W'(DOC_PERIOD - 2);
         busy_run <= '0;
      end else begin
         gap      <= doc_enable ? '0 : gap + 1'b1;
         busy_run <= busy ? busy_run + 1'b1 : '0;
      end
   end

   a_write_exclusive: assert property (@(posedge clk) disable iff (reset) !(ram_wr && doc_wr))
      else begin
         $error("ram_wr and doc_wr high in the same cycle");
         fail_count++;
      end

   a_write_in_slot: assert property (@(posedge clk) disable iff (reset)
      (ram_wr || doc_wr) |-> $past(doc_enable))
      else begin
         $error("write pulse outside the cycle after doc_enable");
         fail_count++;
      end

   a_slot_period: assert property (@(posedge clk) disable iff (reset)
      doc_enable == (gap == PHASE_W'(DOC_PERIOD - 1)))
      else begin
         $error("doc_enable not spaced by the slot period");
         fail_count++;
      end

   a_busy_clears: assert property (@(posedge clk) disable iff (reset) busy_run <= DOC_PERIOD)
      else begin
         $error("busy held longer than one slot period");
         fail_count++;
      end

   // Halted voices give a silent mixer output on the next slot
   a_halted_silent: assert property (@(posedge clk) disable iff (reset)
      (doc_enable && (&osc_halt)) |=> (audio_out == 12'd0))
      else begin
         $error("audio_out not zero with all oscillators halted");
         fail_count++;
      end

endmodule

`default_nettype wire

// File: dv/sound_tb.sv
`timescale 1ns/1ns
`default_nettype none

module sound_tb import sound_pkg::*; ();

   localparam logic [15:0] RAM_BASE    = 16'h1234;
   localparam int          AUDIO_SLOTS = 300;
   // Roughly 110 data accesses of up to 40 cycles, plus the audio wait, with margin
   localparam int          TIMEOUT_CYCLES = 20000;

   logic        clk;
   logic        reset;
   logic        select;
   logic        wr;
   logic [1:0]  host_addr;
   logic [7:0]  host_data_in;
   logic [7:0]  host_data_out;
   logic [11:0] audio_out;
   int          errors;
   int unsigned seed;
   logic [7:0]  ram_bytes [16];
   logic [7:0]  doc_expect [NUM_OSC][4];
   logic [7:0]  bank_base [4] = '{8'h00, 8'h20, 8'h40, 8'hA0};

   sound_top u_sound_top (.*);

   bind sound_top sound_assertions u_sound_assertions (.*, .busy(u_sound_glu.busy));

   always #4 clk = ~clk;

   function automatic logic [7:0] next_random();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed[23:16];
   endfunction

   // SNDCTL readback layout with the access idle
   function automatic logic [7:0] expected_ctl(input logic [7:0] written);
      return {1'b0, written[6], written[5], 1'b1, written[3:0]};
   endfunction

   task automatic check(input string name, input logic [7:0] expected,
                        input logic [7:0] actual);
      assert (actual === expected)
      else begin
         errors++;
         $display("error %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic bus_cycle(input glu_reg_e reg_sel, input logic write,
                            input logic [7:0] din, output logic [7:0] dout);
      @(posedge clk);
      #1;
      select       = 1'b1;
      wr           = write;
      host_addr    = reg_sel;
      host_data_in = din;
      repeat (2) @(posedge clk);
      #1;
      dout   = host_data_out;   // Registered one cycle after the select edge
      select = 1'b0;
   endtask

   // Data accesses are followed by polling busy in SNDCTL
   task automatic host_access(input glu_reg_e reg_sel, input logic write,
                              input logic [7:0] din, output logic [7:0] dout);
      logic [7:0] status;
      bus_cycle(reg_sel, write, din, dout);
      status = {reg_sel == SNDDATA, 7'd0};
      while (status[7]) begin
         bus_cycle(SNDCTL, 1'b0, 8'h00, status);
      end
   endtask

   task automatic set_address(input logic [15:0] addr);
      logic [7:0] ignored;
      host_access(SNDAPL, 1'b1, addr[7:0], ignored);
      host_access(SNDAPH, 1'b1, addr[15:8], ignored);
   endtask

   task automatic check_pointer(input string name, input logic [15:0] expected);
      logic [7:0] value;
      host_access(SNDAPL, 1'b0, 8'h00, value);
      check(name, expected[7:0], value);
      host_access(SNDAPH, 1'b0, 8'h00, value);
      check(name, expected[15:8], value);
   endtask

   task automatic write_doc_reg(input logic [7:0] reg_addr, input logic [7:0] data);
      logic [7:0] ignored;
      host_access(SNDAPL, 1'b1, reg_addr, ignored);
      host_access(SNDDATA, 1'b1, data, ignored);
   endtask

   // First read only starts the fetch
   task automatic read_doc_reg(input logic [7:0] reg_addr, output logic [7:0] data);
      host_access(SNDAPL, 1'b1, reg_addr, data);
      host_access(SNDDATA, 1'b0, 8'h00, data);
      host_access(SNDDATA, 1'b0, 8'h00, data);
   endtask

   initial begin
      logic [7:0]  value;
      logic [11:0] start_audio;
      int          cycles;

      clk          = 1'b0;
      reset        = 1'b1;
      select       = 1'b0;
      wr           = 1'b0;
      host_addr    = 2'd0;
      host_data_in = 8'd0;
      errors       = 0;
      seed         = 23;
      repeat (8) @(posedge clk);
      #1;
      reset = 1'b0;

      host_access(SNDCTL, 1'b1, 8'hEA, value);
      host_access(SNDCTL, 1'b0, 8'h00, value);
      check("ctl_fields_a", expected_ctl(8'hEA), value);
      host_access(SNDCTL, 1'b1, 8'h05, value);
      host_access(SNDCTL, 1'b0, 8'h00, value);
      check("ctl_fields_b", expected_ctl(8'h05), value);

      // Sound RAM with auto-increment
      host_access(SNDCTL, 1'b1, 8'h60, value);
      set_address(RAM_BASE);
      check_pointer("pointer_written", RAM_BASE);
      for (int i = 0; i < 16; i++) begin
         ram_bytes[i] = next_random();
         host_access(SNDDATA, 1'b1, ram_bytes[i], value);
      end
      check_pointer("pointer_incremented", RAM_BASE + 16'd16);
      set_address(RAM_BASE);
      host_access(SNDDATA, 1'b0, 8'h00, value);   // Stale byte
      for (int i = 0; i < 16; i++) begin
         host_access(SNDDATA, 1'b0, 8'h00, value);
         check("ram_round_trip", ram_bytes[i], value);
      end
      host_access(SNDCTL, 1'b1, 8'h40, value);
      host_access(SNDDATA, 1'b0, 8'h00, value);
      check_pointer("pointer_held", RAM_BASE + 16'd17);

      // Synthesizer registers, voices kept halted
      host_access(SNDCTL, 1'b1, 8'h00, value);
      for (int o = 0; o < NUM_OSC; o++) begin
         for (int b = 0; b < 4; b++) begin
            value = next_random();
            if (b == 3) value = value | 8'h01;
            doc_expect[o][b] = (b == 3) ? 8'h01 : value;
            write_doc_reg(bank_base[b] + 8'(o), value);
         end
      end
      for (int o = 0; o < NUM_OSC; o++) begin
         for (int b = 0; b < 4; b++) begin
            read_doc_reg(bank_base[b] + 8'(o), value);
            check("doc_register", doc_expect[o][b], value);
         end
      end
      read_doc_reg(8'h04, value);
      check("doc_unmapped_osc", 8'h00, value);
      read_doc_reg(8'h60, value);
      check("doc_unmapped_bank", 8'h00, value);

      host_access(SNDCTL, 1'b1, 8'h0F, value);
      repeat (4 * DOC_PERIOD) @(posedge clk);
      write_doc_reg(8'h20, 8'h80);   // Oscillator 0 at frequency 0x80xx
      write_doc_reg(8'h40, 8'hFF);
      write_doc_reg(8'hA0, 8'h00);   // Release halt
      start_audio = audio_out;
      cycles      = 0;
      while (audio_out == start_audio && cycles < AUDIO_SLOTS * DOC_PERIOD) begin
         @(posedge clk);
         #1;
         cycles++;
      end
      assert (audio_out != start_audio)
      else begin
         errors++;
         $display("audio_out did not change within %0d slots of enabling a voice", AUDIO_SLOTS);
      end
      host_access(SNDCTL, 1'b1, 8'h00, value);
      repeat (DOC_PERIOD + 2) @(posedge clk);
      #1;
      assert (audio_out == 12'd0)
      else begin
         errors++;
         $display("error audio_mute: expected %h, actual %h", 12'd0, audio_out);
      end

      $display("check errors: %0d, assertion failures: %0d", errors,
               u_sound_top.u_sound_assertions.fail_count);
      if (errors == 0 && u_sound_top.u_sound_assertions.fail_count == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      int cycles;
      cycles = 0;
      while (cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
hw/sound_pkg.sv
hw/sound_glu.sv
hw/sound_ram.sv
hw/doc_regs.sv
hw/doc_oscillator.sv
hw/doc_mixer.sv
hw/sound_top.sv
dv/sound_assertions.sv
dv/sound_tb.sv

// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module sound_tb -Mdir obj_dir

# Exit status comes from the search for the pass line
run: compile
	./obj_dir/Vsound_tb +verilator+error+limit+1000 | tee /dev/stderr | grep "RESULT: PASS" > /dev/null

clean:
	rm -rf obj_dir
